// ==== hw/rx_link_defs.svh ====
// control codes, head flag and holdoff constants for the receive link; include where needed
`ifndef RX_LINK_DEFS_SVH
`define RX_LINK_DEFS_SVH

////////////////////////////////////////
// link control codes
////////////////////////////////////////

// idle sync word D5.6/K28.5, only the low K flag set
`define RX_SYNC_WORD 16'hC5BC

// start of frame K28.2/K27.7, both K flags set
`define RX_SOF_WORD 16'h5CFB

// head flag, two words back to back
`define RX_HEAD_FLAG 32'hEB90_E116

// all-K word seen when the link drops
`define RX_LINK_LOSS_WORD 16'hFFFF

////////////////////////////////////////
// parser and loss timing
////////////////////////////////////////

`define RX_STATE_W 4

// about 100 ms at the link clock
`define RX_HOLDOFF_DEFAULT 24'd10_000_000

`endif

// ==== hw/rx_link_pkg.sv ====
// shared types for the receive link: parser state encoding and the captured frame header
`include "rx_link_defs.svh"

package rx_link_pkg;

    // parser states, one word per state from data type onward
    typedef enum logic [`RX_STATE_W-1:0] {
        st_idle       = 4'd0,
        st_sync       = 4'd1,
        st_frame_head = 4'd2,
        st_data_type  = 4'd3,
        st_line_info  = 4'd4,
        st_data_len   = 4'd5,
        st_recv_data  = 4'd6,
        st_check      = 4'd7,
        st_end1       = 4'd8,
        st_end2       = 4'd9
    } rx_state_e;

    // header fields as captured from the data type, line and length words
    typedef struct packed {
        logic        file_end;
        logic [1:0]  channel_id;
        logic [3:0]  data_type;
        logic [23:0] line_num;
        logic [15:0] data_len;
    } rx_header_t;

endpackage

// ==== hw/frame_info_if.sv ====
// completed-frame information from the frame parser to the interrupt controller and top
`timescale 1ns/1ps

interface frame_info_if (
    input logic i_2711_rx_clk
);

    rx_link_pkg::rx_header_t header;

    // high for one cycle in the line info state
    logic line_seen;
    // high for one cycle in the first end state
    logic frame_done;
    // valid from the check state until the next frame head
    logic checksum_err;

    modport parser (
        input  i_2711_rx_clk,
        output header,
        output line_seen,
        output frame_done,
        output checksum_err
    );

    modport intr (
        input i_2711_rx_clk,
        input header,
        input line_seen,
        input frame_done,
        input checksum_err
    );

endinterface

// ==== hw/frame_parser.sv ====
// receive frame FSM: finds sync, SOF and head flag, captures the header and checks the checksum
`timescale 1ns/1ps
`include "rx_link_defs.svh"

module frame_parser (
    input  logic                i_2711_rx_clk,
    input  logic                i_rst_n,
    input  logic                i_2711_rkmsb,
    input  logic                i_2711_rklsb,
    input  logic [15:0]         i_2711_rxd,
    input  logic                i_rx_length_unit,
    frame_info_if.parser        o_frame,
    output logic                o_in_frame
);

    rx_link_pkg::rx_state_e state;
    rx_link_pkg::rx_state_e state_nxt;

    logic [15:0] prev_word;
    logic [15:0] data_cnt;
    logic [15:0] data_words;
    logic [15:0] checksum;

    // length is in bytes unless the 2-byte unit is selected
    assign data_words = i_rx_length_unit ? o_frame.header.data_len
                                         : {1'b0, o_frame.header.data_len[15:1]};

    assign o_in_frame = (state >= rx_link_pkg::st_data_type) &&
                        (state <= rx_link_pkg::st_check);

    ////////////////////////////////////////
    // state register and next state
    ////////////////////////////////////////

    always_ff @(posedge i_2711_rx_clk) begin
        if (!i_rst_n) begin
            state <= rx_link_pkg::st_idle;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        unique case (state)
            rx_link_pkg::st_idle: begin
                if (!i_2711_rkmsb && i_2711_rklsb && i_2711_rxd == `RX_SYNC_WORD) begin
                    state_nxt = rx_link_pkg::st_sync;
                end
            end
            rx_link_pkg::st_sync: begin
                if (i_2711_rkmsb && i_2711_rklsb && i_2711_rxd == `RX_SOF_WORD) begin
                    state_nxt = rx_link_pkg::st_frame_head;
                end
            end
            rx_link_pkg::st_frame_head: begin
                // head flag spans the previous and current word
                if ({prev_word, i_2711_rxd} == `RX_HEAD_FLAG) begin
                    state_nxt = rx_link_pkg::st_data_type;
                end
            end
            rx_link_pkg::st_data_type: state_nxt = rx_link_pkg::st_line_info;
            rx_link_pkg::st_line_info: state_nxt = rx_link_pkg::st_data_len;
            rx_link_pkg::st_data_len:  state_nxt = rx_link_pkg::st_recv_data;
            rx_link_pkg::st_recv_data: begin
                // length of at least one data word assumed
                if (data_cnt == data_words - 16'd1) begin
                    state_nxt = rx_link_pkg::st_check;
                end
            end
            rx_link_pkg::st_check: state_nxt = rx_link_pkg::st_end1;
            rx_link_pkg::st_end1:  state_nxt = rx_link_pkg::st_end2;
            default:               state_nxt = rx_link_pkg::st_idle;
        endcase
    end

    always_ff @(posedge i_2711_rx_clk) begin
        prev_word <= i_2711_rxd;
    end

    ////////////////////////////////////////
    // header capture and data count
    ////////////////////////////////////////

    always_ff @(posedge i_2711_rx_clk) begin
        if (!i_rst_n) begin
            o_frame.header <= '0;
            data_cnt       <= 16'd0;
        end else begin
            if (state == rx_link_pkg::st_data_type) begin
                // bit 15 of this word is reserved
                o_frame.header.file_end         <= i_2711_rxd[14];
                o_frame.header.channel_id       <= i_2711_rxd[13:12];
                o_frame.header.data_type        <= i_2711_rxd[11:8];
                o_frame.header.line_num[23:16]  <= i_2711_rxd[7:0];
            end
            if (state == rx_link_pkg::st_line_info) begin
                o_frame.header.line_num[15:0] <= i_2711_rxd;
            end
            if (state == rx_link_pkg::st_data_len) begin
                o_frame.header.data_len <= i_2711_rxd;
            end
            if (state == rx_link_pkg::st_recv_data) begin
                data_cnt <= data_cnt + 16'd1;
            end else begin
                data_cnt <= 16'd0;
            end
        end
    end

    ////////////////////////////////////////
    // checksum and frame pulses
    ////////////////////////////////////////

    always_ff @(posedge i_2711_rx_clk) begin
        if (!i_rst_n) begin
            checksum             <= 16'd0;
            o_frame.checksum_err <= 1'b0;
            o_frame.line_seen    <= 1'b0;
            o_frame.frame_done   <= 1'b0;
        end else begin
            unique case (state)
                rx_link_pkg::st_frame_head: begin
                    checksum             <= 16'd0;
                    o_frame.checksum_err <= 1'b0;
                end
                rx_link_pkg::st_data_type, rx_link_pkg::st_line_info,
                rx_link_pkg::st_data_len, rx_link_pkg::st_recv_data: begin
                    checksum <= checksum + i_2711_rxd;
                end
                rx_link_pkg::st_check: begin
                    o_frame.checksum_err <= (checksum != i_2711_rxd);
                end
                default: begin
                    checksum <= checksum;
                end
            endcase
            // data type always leads to line info, check to end one
            o_frame.line_seen  <= (state == rx_link_pkg::st_data_type);
            o_frame.frame_done <= (state == rx_link_pkg::st_check);
        end
    end

    a_state_legal: assert property (@(posedge i_2711_rx_clk) disable iff (!i_rst_n)
        !$isunknown(state) && state <= rx_link_pkg::st_end2);

endmodule

// ==== hw/loss_holdoff.sv ====
// single-cycle loss pulse with a holdoff window; one instance per loss event kind
`timescale 1ns/1ps

module loss_holdoff #(
    parameter int p_holdoff_cycles = 64
) (
    input  logic i_2711_rx_clk,
    input  logic i_rst_n,
    input  logic i_ena,
    input  logic i_event,
    output logic o_pulse
);

    // holdoff covers the pulse cycle and the programmed cycles after it
    localparam logic [23:0] lp_limit = 24'(p_holdoff_cycles);

    logic        holdoff;
    logic        accept;
    logic [23:0] timer;

    // an event counts only outside the holdoff window
    assign accept = i_event && !holdoff;

    always_ff @(posedge i_2711_rx_clk) begin
        if (!i_rst_n) begin
            o_pulse <= 1'b0;
            holdoff <= 1'b0;
            timer   <= 24'd0;
        end else if (!i_ena) begin
            // disabling drops any running holdoff
            o_pulse <= 1'b0;
            holdoff <= 1'b0;
            timer   <= 24'd0;
        end else begin
            o_pulse <= accept;
            if (accept) begin
                holdoff <= 1'b1;
                timer   <= 24'd0;
            end else if (holdoff) begin
                if (timer == lp_limit) begin
                    holdoff <= 1'b0;
                    timer   <= 24'd0;
                end else begin
                    timer <= timer + 24'd1;
                end
            end
        end
    end

    a_single_pulse: assert property (@(posedge i_2711_rx_clk) disable iff (!i_rst_n)
        o_pulse |=> !o_pulse);

endmodule

// ==== hw/loss_monitor.sv ====
// link-loss and sync-loss detection, each through its own holdoff
`timescale 1ns/1ps
`include "rx_link_defs.svh"

module loss_monitor #(
    parameter int p_holdoff_cycles = 64
) (
    input  logic        i_2711_rx_clk,
    input  logic        i_rst_n,
    input  logic        i_2711_rkmsb,
    input  logic        i_2711_rklsb,
    input  logic [15:0] i_2711_rxd,
    input  logic        i_in_frame,
    input  logic        i_link_loss_detect_ena,
    input  logic        i_sync_loss_detect_ena,
    output logic        o_link_loss,
    output logic        o_sync_loss
);

    logic link_loss_evt;
    logic sync_loss_evt;

    // all-K FFFF means the far end stopped sending
    assign link_loss_evt = i_2711_rkmsb && i_2711_rklsb && (i_2711_rxd == `RX_LINK_LOSS_WORD);

    // no K character belongs between the head flag and the checksum
    assign sync_loss_evt = (i_2711_rkmsb || i_2711_rklsb) && i_in_frame;

    loss_holdoff #(
        .p_holdoff_cycles(p_holdoff_cycles)
    ) u_link_holdoff (
        .i_2711_rx_clk(i_2711_rx_clk),
        .i_rst_n      (i_rst_n),
        .i_ena        (i_link_loss_detect_ena),
        .i_event      (link_loss_evt),
        .o_pulse      (o_link_loss)
    );

    loss_holdoff #(
        .p_holdoff_cycles(p_holdoff_cycles)
    ) u_sync_holdoff (
        .i_2711_rx_clk(i_2711_rx_clk),
        .i_rst_n      (i_rst_n),
        .i_ena        (i_sync_loss_detect_ena),
        .i_event      (sync_loss_evt),
        .o_pulse      (o_sync_loss)
    );

endmodule

// ==== hw/rx_intr_ctrl.sv ====
// line-count interrupt of programmed width, plus the merged loss interrupt
`timescale 1ns/1ps

module rx_intr_ctrl (
    input  logic        i_2711_rx_clk,
    input  logic        i_rst_n,
    frame_info_if.intr  i_frame,
    input  logic [23:0] i_rx_line_num_per_intr,
    input  logic [15:0] i_rx_intr_width,
    input  logic        i_link_loss,
    input  logic        i_sync_loss,
    output logic        o_rx_interrupt,
    output logic        o_loss_interrupt
);

    logic [23:0] line_cnt;
    logic [15:0] width_cnt;
    logic        intr_gen;

    assign intr_gen = i_frame.frame_done && (line_cnt == i_rx_line_num_per_intr);

    assign o_loss_interrupt = i_link_loss || i_sync_loss;

    // count frame headers, start over once the interrupt is out
    always_ff @(posedge i_2711_rx_clk) begin
        if (!i_rst_n) begin
            line_cnt <= 24'd0;
        end else if (i_frame.line_seen) begin
            line_cnt <= line_cnt + 24'd1;
        end else if (o_rx_interrupt) begin
            line_cnt <= 24'd0;
        end
    end

    ////////////////////////////////////////
    // interrupt width
    ////////////////////////////////////////

    always_ff @(posedge i_2711_rx_clk) begin
        if (!i_rst_n) begin
            o_rx_interrupt <= 1'b0;
            width_cnt      <= 16'd0;
        end else if (o_rx_interrupt) begin
            if (i_rx_intr_width == 16'd0 || width_cnt == i_rx_intr_width - 16'd1) begin
                o_rx_interrupt <= 1'b0;
                width_cnt      <= 16'd0;
            end else begin
                width_cnt <= width_cnt + 16'd1;
            end
        end else if (intr_gen && i_rx_intr_width != 16'd0) begin
            o_rx_interrupt <= 1'b1;
            width_cnt      <= 16'd0;
        end
    end

    a_no_zero_width: assert property (@(posedge i_2711_rx_clk) disable iff (!i_rst_n)
        (i_rx_intr_width == 16'd0) |=> !o_rx_interrupt);

endmodule

// ==== hw/rx_link_top.sv ====
// receive link top: frame parser, loss monitor and interrupt controller on one clock
`timescale 1ns/1ps
`include "rx_link_defs.svh"

module rx_link_top #(
    parameter int p_holdoff_cycles = `RX_HOLDOFF_DEFAULT
) (
    input  logic        i_2711_rx_clk,
    input  logic        i_rst_n,
    input  logic        i_2711_rkmsb,
    input  logic        i_2711_rklsb,
    input  logic [15:0] i_2711_rxd,
    input  logic        i_rx_length_unit,
    input  logic [23:0] i_rx_line_num_per_intr,
    input  logic [15:0] i_rx_intr_width,
    input  logic        i_link_loss_detect_ena,
    input  logic        i_sync_loss_detect_ena,
    output logic        o_rx_frame_done,
    output logic [23:0] o_rx_frame_num,
    output logic [15:0] o_rx_frame_length,
    output logic [3:0]  o_rx_data_type,
    output logic [1:0]  o_rx_channel_id,
    output logic        o_rx_file_end_flag,
    output logic        o_rx_checksum_flag,
    output logic        o_rx_interrupt,
    output logic        o_loss_interrupt,
    output logic        o_link_loss,
    output logic        o_sync_loss
);

    logic in_frame;

    frame_info_if u_frame_if (
        .i_2711_rx_clk(i_2711_rx_clk)
    );

    frame_parser u_parser (
        .i_2711_rx_clk   (i_2711_rx_clk),
        .i_rst_n         (i_rst_n),
        .i_2711_rkmsb    (i_2711_rkmsb),
        .i_2711_rklsb    (i_2711_rklsb),
        .i_2711_rxd      (i_2711_rxd),
        .i_rx_length_unit(i_rx_length_unit),
        .o_frame         (u_frame_if.parser),
        .o_in_frame      (in_frame)
    );

    loss_monitor #(
        .p_holdoff_cycles(p_holdoff_cycles)
    ) u_loss_mon (
        .i_2711_rx_clk         (i_2711_rx_clk),
        .i_rst_n               (i_rst_n),
        .i_2711_rkmsb          (i_2711_rkmsb),
        .i_2711_rklsb          (i_2711_rklsb),
        .i_2711_rxd            (i_2711_rxd),
        .i_in_frame            (in_frame),
        .i_link_loss_detect_ena(i_link_loss_detect_ena),
        .i_sync_loss_detect_ena(i_sync_loss_detect_ena),
        .o_link_loss           (o_link_loss),
        .o_sync_loss           (o_sync_loss)
    );

    rx_intr_ctrl u_intr (
        .i_2711_rx_clk         (i_2711_rx_clk),
        .i_rst_n               (i_rst_n),
        .i_frame               (u_frame_if.intr),
        .i_rx_line_num_per_intr(i_rx_line_num_per_intr),
        .i_rx_intr_width       (i_rx_intr_width),
        .i_link_loss           (o_link_loss),
        .i_sync_loss           (o_sync_loss),
        .o_rx_interrupt        (o_rx_interrupt),
        .o_loss_interrupt      (o_loss_interrupt)
    );

    // frame results straight from the parser registers
    assign o_rx_frame_done    = u_frame_if.frame_done;
    assign o_rx_frame_num     = u_frame_if.header.line_num;
    assign o_rx_frame_length  = u_frame_if.header.data_len;
    assign o_rx_data_type     = u_frame_if.header.data_type;
    assign o_rx_channel_id    = u_frame_if.header.channel_id;
    assign o_rx_file_end_flag = u_frame_if.header.file_end;
    assign o_rx_checksum_flag = u_frame_if.checksum_err;

endmodule

// ==== dv/tb_rx_link.sv ====
// testbench for the receive link; replays dv/rx_link_golden.txt against the DUT and checks results
`timescale 1ns/1ps

module tb_rx_link;

    localparam logic [15:0] lp_idle_word = 16'hC5BC;
    localparam logic [15:0] lp_sof_word  = 16'h5CFB;

    // one golden record, field 0 holds the command letter
    typedef logic [7:0][31:0] rec_t;

    logic        clk;
    logic        rst_n;
    logic        rkmsb;
    logic        rklsb;
    logic [15:0] rxd;
    logic        length_unit;
    logic [23:0] line_num_per_intr;
    logic [15:0] intr_width;
    logic        link_ena;
    logic        sync_ena;
    logic        frame_done;
    logic [23:0] frame_num;
    logic [15:0] frame_length;
    logic [3:0]  data_type;
    logic [1:0]  channel_id;
    logic        file_end_flag;
    logic        checksum_flag;
    logic        rx_interrupt;
    logic        loss_interrupt;
    logic        link_loss;
    logic        sync_loss;

    rec_t        rec_q[$];
    logic [47:0] cap_q[$];
    int          seed = 49367;
    int          cycle_cnt = 0;
    int          cycle_limit = 0;
    int          err_cnt = 0;
    int          frame_cnt = 0;
    int          link_cnt = 0;
    int          sync_cnt = 0;
    int          loss_cnt = 0;
    int          rxint_cnt = 0;
    int          intr_len = 0;
    logic        intr_prev = 1'b0;
    logic        done_prev = 1'b0;

    rx_link_top #(
        .p_holdoff_cycles(64)
    ) DUT (
        .i_2711_rx_clk         (clk),
        .i_rst_n               (rst_n),
        .i_2711_rkmsb          (rkmsb),
        .i_2711_rklsb          (rklsb),
        .i_2711_rxd            (rxd),
        .i_rx_length_unit      (length_unit),
        .i_rx_line_num_per_intr(line_num_per_intr),
        .i_rx_intr_width       (intr_width),
        .i_link_loss_detect_ena(link_ena),
        .i_sync_loss_detect_ena(sync_ena),
        .o_rx_frame_done       (frame_done),
        .o_rx_frame_num        (frame_num),
        .o_rx_frame_length     (frame_length),
        .o_rx_data_type        (data_type),
        .o_rx_channel_id       (channel_id),
        .o_rx_file_end_flag    (file_end_flag),
        .o_rx_checksum_flag    (checksum_flag),
        .o_rx_interrupt        (rx_interrupt),
        .o_loss_interrupt      (loss_interrupt),
        .o_link_loss           (link_loss),
        .o_sync_loss           (sync_loss)
    );

    always #10 clk = ~clk;

    task automatic fail_now();
        err_cnt = err_cnt + 1;
        $display("Testbench failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_hex(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got == exp) else begin
            $display("** Error: %s = %h, expected %h", name, got, exp);
            fail_now();
        end
    endtask

    // one word per cycle, driven just after the rising edge
    task automatic drive_word(input logic km, input logic kl, input logic [15:0] word);
        @(posedge clk);
        #2;
        rkmsb = km;
        rklsb = kl;
        rxd   = word;
    endtask

    task automatic drive_idle(input int count);
        int n;
        for (n = 0; n < count; n++) begin
            drive_word(1'b0, 1'b1, lp_idle_word);
        end
    endtask

    function automatic int record_fields(input logic [7:0] cmd);
        case (cmd)
            "c":     return 5;
            "w":     return 3;
            "i":     return 1;
            "f":     return 7;
            "e":     return 6;
            "k":     return 5;
            default: return 0;
        endcase
    endfunction

    ////////////////////////////////////////
    // frame builder
    ////////////////////////////////////////

    // sync, SOF, head flag, header, random data, checksum and two idle words
    task automatic send_frame(input rec_t r);
        logic [15:0] type_word;
        logic [15:0] line_word;
        logic [15:0] len_word;
        logic [15:0] data_word;
        logic [15:0] sum;
        int          ndata;
        int          n;
        type_word = {1'b0, r[1][0], r[2][1:0], r[3][3:0], r[4][23:16]};
        line_word = r[4][15:0];
        len_word  = r[5][15:0];
        // byte count halves into words unless the 2-byte unit is set
        ndata = length_unit ? int'(len_word) : int'(len_word >> 1);
        if (ndata == 0) begin
            $display("frame record in the golden file gives no data words");
            fail_now();
        end
        sum = type_word + line_word + len_word;
        drive_word(1'b0, 1'b1, lp_idle_word);
        drive_word(1'b1, 1'b1, lp_sof_word);
        drive_word(1'b0, 1'b0, 16'hEB90);
        drive_word(1'b0, 1'b0, 16'hE116);
        drive_word(1'b0, 1'b0, type_word);
        drive_word(1'b0, 1'b0, line_word);
        drive_word(1'b0, 1'b0, len_word);
        for (n = 1; n <= ndata; n++) begin
            data_word = 16'($random(seed));
            sum       = sum + data_word;
            drive_word(1'b0, (n == int'(r[7])), data_word);
        end
        drive_word(1'b0, 1'b0, sum ^ r[6][15:0]);
        drive_idle(2);
    endtask

    ////////////////////////////////////////
    // output monitor, sampled mid-cycle
    ////////////////////////////////////////

    always @(negedge clk) begin
        if (rst_n) begin
            if (frame_done) begin
                frame_cnt = frame_cnt + 1;
                cap_q.push_back({frame_num, frame_length, data_type, channel_id,
                                 file_end_flag, checksum_flag});
            end
            link_cnt = link_cnt + int'(link_loss);
            sync_cnt = sync_cnt + int'(sync_loss);
            loss_cnt = loss_cnt + int'(loss_interrupt);
            if (rx_interrupt) begin
                if (!intr_prev) begin
                    rxint_cnt = rxint_cnt + 1;
                    assert (done_prev) else begin
                        $display("o_rx_interrupt rose without a frame_done just before");
                        fail_now();
                    end
                end
                intr_len = intr_len + 1;
            end else if (intr_prev) begin
                check_hex("o_rx_interrupt width", 32'(intr_len), 32'(intr_width));
                intr_len = 0;
            end
            intr_prev = rx_interrupt;
            done_prev = frame_done;
        end
    end

    // limit from the word count of the golden file
    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_limit != 0 && cycle_cnt > cycle_limit) begin
            $display("timeout after %0d cycles, stimulus did not finish", cycle_cnt);
            $display("Testbench failed");
            $fatal(1, "timeout");
        end
    end

    initial begin
        int          fd;
        int          code;
        int          nf;
        int          idx;
        int          words;
        logic        unit;
        logic [63:0] tok;
        logic [31:0] val;
        logic [8*256-1:0] line_buf;
        logic [47:0] cap;
        rec_t        rec;
        clk = 1'b0;
        rst_n = 1'b0;
        rkmsb = 1'b0;
        rklsb = 1'b0;
        rxd = 16'h0000;
        length_unit = 1'b0;
        line_num_per_intr = 24'd2;
        intr_width = 16'd5;
        link_ena = 1'b1;
        sync_ena = 1'b1;
        fd = $fopen("dv/rx_link_golden.txt", "r");
        if (fd == 0) begin
            $display("cannot open dv/rx_link_golden.txt");
            fail_now();
        end
        while (!$feof(fd)) begin
            tok  = '0;
            code = $fscanf(fd, "%s", tok);
            if (code == 1) begin
                if (tok[7:0] == "#") begin
                    code = $fgets(line_buf, fd);
                end else begin
                    rec    = '0;
                    rec[0] = tok[31:0];
                    nf     = record_fields(tok[7:0]);
                    if (nf == 0) begin
                        $display("unknown record in the golden file");
                        fail_now();
                    end
                    for (idx = 1; idx <= nf; idx++) begin
                        code     = $fscanf(fd, "%h", val);
                        rec[idx] = val;
                    end
                    rec_q.push_back(rec);
                end
            end
        end
        $fclose(fd);

        // words on the link, tracking the unit that sets each frame's length
        words = 8;
        unit  = 1'b0;
        foreach (rec_q[idx]) begin
            case (rec_q[idx][0][7:0])
                "c":     unit = rec_q[idx][1][0];
                "w":     words = words + 1;
                "i":     words = words + int'(rec_q[idx][1]);
                "f":     words = words + 10 + int'(unit ? rec_q[idx][5] : rec_q[idx][5] >> 1);
                "k":     words = words + 4;
                default: words = words + 0;
            endcase
        end
        cycle_limit = 2 * words + 200;

        repeat (16) @(posedge clk);
        #2;
        rst_n = 1'b1;

        for (idx = 0; idx < rec_q.size(); idx++) begin
            rec = rec_q[idx];
            case (rec[0][7:0])
                "c": begin
                    length_unit       = rec[1][0];
                    line_num_per_intr = rec[2][23:0];
                    intr_width        = rec[3][15:0];
                    link_ena          = rec[4][0];
                    sync_ena          = rec[5][0];
                end
                "w": drive_word(rec[1][0], rec[2][0], rec[3][15:0]);
                "i": drive_idle(int'(rec[1]));
                "f": send_frame(rec);
                "e": begin
                    while (cap_q.size() == 0) begin
                        drive_idle(1);
                    end
                    cap = cap_q.pop_front();
                    check_hex("o_rx_frame_num", 32'(cap[47:24]), rec[1]);
                    check_hex("o_rx_frame_length", 32'(cap[23:8]), rec[2]);
                    check_hex("o_rx_data_type", 32'(cap[7:4]), rec[3]);
                    check_hex("o_rx_channel_id", 32'(cap[3:2]), rec[4]);
                    check_hex("o_rx_file_end_flag", 32'(cap[1]), rec[5]);
                    check_hex("o_rx_checksum_flag", 32'(cap[0]), rec[6]);
                end
                default: begin
                    // pulses land one cycle after their cause
                    drive_idle(4);
                    check_hex("o_rx_frame_done count", 32'(frame_cnt), rec[1]);
                    check_hex("o_link_loss count", 32'(link_cnt), rec[2]);
                    check_hex("o_sync_loss count", 32'(sync_cnt), rec[3]);
                    check_hex("o_loss_interrupt count", 32'(loss_cnt), rec[4]);
                    check_hex("o_rx_interrupt count", 32'(rxint_cnt), rec[5]);
                    frame_cnt = 0;
                    link_cnt  = 0;
                    sync_cnt  = 0;
                    loss_cnt  = 0;
                    rxint_cnt = 0;
                end
            endcase
        end

        drive_idle(8);
        assert (cap_q.size() == 0) else begin
            $display("frame_done seen with no expect record left for it");
            fail_now();
        end
        if (err_cnt == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// ==== dv/rx_link_golden.txt ====
# hex fields: c unit line_target intr_width link_ena sync_ena | w kmsb klsb word | i idle_words
# f file_end chan type line len cksum_xor k_at_data | e line len type chan file_end cksum_err | k frames link sync loss rx_intr
c 0 2 5 1 1
i 8
f 0 1 3 012345 0008 0000 0
e 012345 0008 3 1 0 0
k 1 0 0 0 0
c 1 2 5 1 1
f 1 2 a abcdef 0006 0000 0
e abcdef 0006 a 2 1 0
k 1 0 0 0 1
i 0a
c 0 2 5 1 1
f 0 3 f 000100 0010 0040 0
e 000100 0010 f 3 0 1
k 1 0 0 0 0
c 1 2 5 1 1
f 1 0 5 7fffff 0002 0000 0
e 7fffff 0002 5 0 1 0
k 1 0 0 0 1
i 0a
w 1 1 ffff
k 0 1 0 1 0
i 8
w 1 1 ffff
k 0 0 0 0 0
i 48
w 1 1 ffff
k 0 1 0 1 0
w 1 0 0055
k 0 0 0 0 0
c 0 2 5 1 0
f 0 0 1 000010 0004 0000 2
e 000010 0004 1 0 0 0
k 1 0 0 0 0
c 0 2 5 1 1
f 0 0 1 000011 0004 0000 1
e 000011 0004 1 0 0 0
k 1 0 1 1 1

// ==== project.f ====
+incdir+hw
hw/rx_link_pkg.sv
hw/frame_info_if.sv
hw/frame_parser.sv
hw/loss_holdoff.sv
hw/loss_monitor.sv
hw/rx_intr_ctrl.sv
hw/rx_link_top.sv
dv/tb_rx_link.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the receive link testbench with Verilator, from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_rx_link -f project.f \
    -Mdir obj_dir -o sim_rx_link > build.log 2>&1 \
    || { echo "build failed, see build.log"; exit 1; }

./obj_dir/sim_rx_link > sim.log 2>&1

grep -q "Testbench failed" sim.log && { echo "simulation reported errors, see sim.log"; exit 1; }
grep -q "Testbench passed" sim.log && { echo "simulation finished cleanly"; exit 0; }
echo "no result found in sim.log"
exit 1
